// File: Makefile
VERILATOR ?= verilator
TOP       ?= loader_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing
PASS_TEXT ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// File: files.f
+incdir+src
src/loader_pkg.sv
src/download_decode.sv
src/halfword_assembler.sv
src/write_router.sv
src/backup_control.sv
src/loader_top.sv
test/clock_gen.sv
test/loader_checker.sv
test/loader_tb.sv

// File: src/backup_control.sv
`include "loader_defines.svh"

module backup_control (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	input  logic                      cart_active,
	input  logic                      cart_start,
	input  logic                      img_mounted,
	input  logic                      img_readonly,
	input  logic [`LOADER_SIZE_W-1:0] img_size,
	input  logic                      osd_status,
	input  logic                      load_req,
	input  logic                      save_req,
	input  logic                      autosave_off,
	output logic                      bk_load,
	output logic                      bk_save,
	output logic                      use_img
);

	logic osd_status_d;
	logic osd_rise;

	// Autosave fires when the OSD opens
	assign osd_rise = osd_status && !osd_status_d;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			osd_status_d <= 1'b0;
			bk_load      <= 1'b0;
			bk_save      <= 1'b0;
			use_img      <= 1'b0;
		end else begin
			osd_status_d <= osd_status;
			bk_load      <= load_req || (cart_active && img_mounted);
			bk_save      <= save_req || (osd_rise && !autosave_off);

			// A new cartridge forgets the old save image
			if (cart_start) begin
				use_img <= 1'b0;
			end
			if (img_mounted && (img_size != '0) && !img_readonly) begin
				use_img <= 1'b1;
			end
		end
	end

endmodule

// File: src/download_decode.sv
`include "loader_defines.svh"

module download_decode (
	input  logic                       clk_1x,
	input  logic                       rst_n,
	input  logic                       ioctl_download,
	input  logic [`LOADER_INDEX_W-1:0] ioctl_index,
	input  logic [`LOADER_ADDR_W-1:0]  ioctl_addr,
	input  logic [`LOADER_HALF_W-1:0]  ioctl_dout,
	input  logic                       ioctl_wr,
	output loader_pkg::dl_target_t     dec_target,
	output logic                       dec_wr,
	output logic [`LOADER_ADDR_W-1:0]  dec_addr,
	output logic [`LOADER_HALF_W-1:0]  dec_data,
	output logic                       dec_index6,
	output logic                       cart_active,
	output logic                       cart_start,
	output logic                       cart_loaded
);
	import loader_pkg::*;

	dl_target_t target_in;

	// Classify by the low six index bits
	always_comb begin
		target_in = TGT_NONE;
		if (ioctl_download) begin
			if (ioctl_index[5:0] == `PIF_INDEX) begin
				target_in = TGT_PIF;
			end else if (ioctl_index[5:0] == `CART_INDEX) begin
				target_in = TGT_CART;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			dec_target  <= TGT_NONE;
			dec_wr      <= 1'b0;
			cart_active <= 1'b0;
			cart_start  <= 1'b0;
			cart_loaded <= 1'b0;
		end else begin
			dec_target  <= target_in;
			// Writes to unknown images are dropped here
			dec_wr      <= ioctl_wr && (target_in != TGT_NONE);
			cart_active <= (target_in == TGT_CART);
			cart_start  <= (target_in == TGT_CART) && !cart_active;
			if (target_in == TGT_CART) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		dec_addr   <= ioctl_addr;
		dec_data   <= ioctl_dout;
		dec_index6 <= ioctl_index[6];
	end

endmodule

// File: src/halfword_assembler.sv
`include "loader_defines.svh"

module halfword_assembler (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	input  loader_pkg::dl_target_t    dec_target,
	input  logic                      dec_wr,
	input  logic [`LOADER_ADDR_W-1:0] dec_addr,
	input  logic [`LOADER_HALF_W-1:0] dec_data,
	input  logic                      dec_index6,
	output logic                      word_valid,
	output loader_pkg::dl_target_t    word_target,
	output logic [`LOADER_ADDR_W-1:0] word_addr,
	output logic [`LOADER_WORD_W-1:0] word_data,
	input  logic                      word_ready,
	output logic                      ioctl_wait
);
	import loader_pkg::*;

	asm_state_t state;
	asm_state_t state_next;
	logic       take;
	logic       high_half;

	// ========================================
	// Control
	// ========================================

	// A new half is taken unless a word is still waiting for ready
	assign take      = dec_wr && ((state != ASM_HOLD) || word_ready);
	assign high_half = dec_addr[1];

	always_comb begin
		state_next = state;
		if (take) begin
			state_next = high_half ? ASM_HOLD : ASM_HIGH;
		end else if ((state == ASM_HOLD) && word_ready) begin
			state_next = ASM_LOW;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			state <= ASM_LOW;
		end else begin
			state <= state_next;
		end
	end

	assign word_valid = (state == ASM_HOLD);

	// Host stalls only behind a cartridge word
	assign ioctl_wait = (state == ASM_HOLD) && (word_target == TGT_CART);

	// ========================================
	// Word payload
	// ========================================

	always_ff @(posedge clk_1x) begin
		if (take) begin
			word_target <= dec_target;
			if (dec_target == TGT_PIF) begin
				// PIF ROM wants each half byte swapped
				if (!high_half) begin
					word_data[31:16] <= {dec_data[7:0], dec_data[15:8]};
					word_addr <= {{(`LOADER_ADDR_W - `PIF_ADDR_W){1'b0}},
						dec_index6, dec_addr[10:2]};
				end else begin
					word_data[15:0] <= {dec_data[7:0], dec_data[15:8]};
				end
			end else begin
				if (!high_half) begin
					word_data[15:0] <= dec_data;
					word_addr       <= dec_addr + `CART_BASE;
				end else begin
					word_data[31:16] <= dec_data;
				end
			end
		end
	end

endmodule

// File: src/loader_defines.svh
`ifndef LOADER_DEFINES_SVH
`define LOADER_DEFINES_SVH

// Host protocol widths
`define LOADER_INDEX_W 8
`define LOADER_ADDR_W  27
`define LOADER_HALF_W  16
`define LOADER_WORD_W  32
`define LOADER_SIZE_W  32

// PIF boot ROM word address
`define PIF_ADDR_W 10

// Image index values in the low six index bits
`define PIF_INDEX  6'd0
`define CART_INDEX 6'd1

// Cartridge image starts at 8 MB in memory
`define CART_BASE 27'd8388608

`endif

// File: src/loader_pkg.sv
package loader_pkg;

	// ========================================
	// Download target
	// ========================================

	typedef enum logic [1:0] {
		TGT_NONE,
		TGT_PIF,
		TGT_CART
	} dl_target_t;

	// ========================================
	// Halfword assembler states
	// ========================================

	// Low half expected, high half expected, word waiting for ready
	typedef enum logic [1:0] {
		ASM_LOW,
		ASM_HIGH,
		ASM_HOLD
	} asm_state_t;

endpackage

// File: src/loader_top.sv
`include "loader_defines.svh"

module loader_top (
	input  logic                       clk_1x,
	input  logic                       rst_n,
	input  logic                       ioctl_download,
	input  logic [`LOADER_INDEX_W-1:0] ioctl_index,
	input  logic [`LOADER_ADDR_W-1:0]  ioctl_addr,
	input  logic [`LOADER_HALF_W-1:0]  ioctl_dout,
	input  logic                       ioctl_wr,
	output logic                       ioctl_wait,
	output logic [`PIF_ADDR_W-1:0]     pif_wraddress,
	output logic [`LOADER_WORD_W-1:0]  pif_wrdata,
	output logic                       pif_wren,
	output logic [`LOADER_ADDR_W-1:0]  mem_addr,
	output logic [`LOADER_WORD_W-1:0]  mem_data,
	output logic                       mem_valid,
	input  logic                       mem_ready,
	input  logic                       img_mounted,
	input  logic                       img_readonly,
	input  logic [`LOADER_SIZE_W-1:0]  img_size,
	input  logic                       osd_status,
	input  logic                       load_req,
	input  logic                       save_req,
	input  logic                       autosave_off,
	output logic                       cart_loaded,
	output logic                       bk_load,
	output logic                       bk_save,
	output logic                       use_img
);
	import loader_pkg::*;

	// ========================================
	// Decode to assembler
	// ========================================
	dl_target_t                dec_target;
	logic                      dec_wr;
	logic [`LOADER_ADDR_W-1:0] dec_addr;
	logic [`LOADER_HALF_W-1:0] dec_data;
	logic                      dec_index6;
	logic                      cart_active;
	logic                      cart_start;

	// ========================================
	// Assembler to router
	// ========================================
	logic                      word_valid;
	dl_target_t                word_target;
	logic [`LOADER_ADDR_W-1:0] word_addr;
	logic [`LOADER_WORD_W-1:0] word_data;
	logic                      word_ready;

	download_decode u_decode (
		.clk_1x         (clk_1x),
		.rst_n          (rst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.dec_target     (dec_target),
		.dec_wr         (dec_wr),
		.dec_addr       (dec_addr),
		.dec_data       (dec_data),
		.dec_index6     (dec_index6),
		.cart_active    (cart_active),
		.cart_start     (cart_start),
		.cart_loaded    (cart_loaded)
	);

	halfword_assembler u_assembler (
		.clk_1x      (clk_1x),
		.rst_n       (rst_n),
		.dec_target  (dec_target),
		.dec_wr      (dec_wr),
		.dec_addr    (dec_addr),
		.dec_data    (dec_data),
		.dec_index6  (dec_index6),
		.word_valid  (word_valid),
		.word_target (word_target),
		.word_addr   (word_addr),
		.word_data   (word_data),
		.word_ready  (word_ready),
		.ioctl_wait  (ioctl_wait)
	);

	write_router u_router (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.word_valid    (word_valid),
		.word_target   (word_target),
		.word_addr     (word_addr),
		.word_data     (word_data),
		.word_ready    (word_ready),
		.pif_wraddress (pif_wraddress),
		.pif_wrdata    (pif_wrdata),
		.pif_wren      (pif_wren),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_valid     (mem_valid),
		.mem_ready     (mem_ready)
	);

	// Save RAM control runs beside the download chain
	backup_control u_backup (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.cart_active  (cart_active),
		.cart_start   (cart_start),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_size     (img_size),
		.osd_status   (osd_status),
		.load_req     (load_req),
		.save_req     (save_req),
		.autosave_off (autosave_off),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.use_img      (use_img)
	);

endmodule

// File: src/write_router.sv
`include "loader_defines.svh"

module write_router (
	input  logic                      clk_1x,
	input  logic                      rst_n,
	input  logic                      word_valid,
	input  loader_pkg::dl_target_t    word_target,
	input  logic [`LOADER_ADDR_W-1:0] word_addr,
	input  logic [`LOADER_WORD_W-1:0] word_data,
	output logic                      word_ready,
	output logic [`PIF_ADDR_W-1:0]    pif_wraddress,
	output logic [`LOADER_WORD_W-1:0] pif_wrdata,
	output logic                      pif_wren,
	output logic [`LOADER_ADDR_W-1:0] mem_addr,
	output logic [`LOADER_WORD_W-1:0] mem_data,
	output logic                      mem_valid,
	input  logic                      mem_ready
);
	import loader_pkg::*;

	logic pif_take;
	logic mem_take;

	assign pif_take = word_valid && (word_target == TGT_PIF);
	// One cartridge request in flight at a time
	assign mem_take = word_valid && (word_target == TGT_CART) && !mem_valid;

	// PIF has no back-pressure; cartridge words complete on the memory handshake
	assign word_ready = (word_target == TGT_CART) ? (mem_valid && mem_ready) : 1'b1;

	always_ff @(posedge clk_1x) begin
		if (!rst_n) begin
			pif_wren  <= 1'b0;
			mem_valid <= 1'b0;
		end else begin
			pif_wren <= pif_take;
			if (mem_take) begin
				mem_valid <= 1'b1;
			end else if (mem_ready) begin
				mem_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (pif_take) begin
			pif_wraddress <= word_addr[`PIF_ADDR_W-1:0];
			pif_wrdata    <= word_data;
		end
		if (mem_take) begin
			mem_addr <= word_addr;
			mem_data <= word_data;
		end
	end

endmodule

// File: test/clock_gen.sv
module clock_gen (
	input  logic reset_req,
	output logic clk_1x,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	initial begin
		clk_1x = 1'b0;
		forever #20 clk_1x = ~clk_1x;
	end

	// Reset low for five cycles at start and after each request
	initial begin
		rst_n = 1'b0;
		forever begin
			repeat (5) @(posedge clk_1x);
			rst_n <= 1'b1;
			@(posedge reset_req);
			@(posedge clk_1x);
			rst_n <= 1'b0;
		end
	end

endmodule

// File: test/loader_checker.sv
`include "loader_defines.svh"

module loader_checker (
	input logic                      clk_1x,
	input logic                      rst_n,
	input logic                      valid,
	input logic                      ready,
	input logic [`LOADER_ADDR_W-1:0] addr,
	input logic [`LOADER_WORD_W-1:0] data,
	input logic                      pulse
);
	timeunit 1ns;
	timeprecision 1ps;

	// ========================================
	// Valid/ready rule
	// ========================================

	property hold_until_ready;
		@(posedge clk_1x) disable iff (!rst_n)
			(valid && !ready) |=> (valid && $stable(data) && $stable(addr));
	endproperty

	assert property (hold_until_ready)
		else $error("valid dropped or payload changed before ready");

	// Write pulse is a single cycle
	property single_cycle_pulse;
		@(posedge clk_1x) disable iff (!rst_n) pulse |=> !pulse;
	endproperty

	assert property (single_cycle_pulse)
		else $error("write pulse lasted two cycles");

endmodule

// File: test/loader_input.txt
# op index addr data expect, all hex
# op: 0 reset, 1 halfword pair, 2 backup event (addr=img_size, data=flags), 3 start, 4 end, 5 cart_loaded
5 00 0000000 00000000 0
3 00 0000000 00000000 0
1 00 0000000 56781234 34127856
1 00 0000004 aabbccdd ddccbbaa
1 00 00007fc 01020304 04030201
4 00 0000000 00000000 0
3 40 0000000 00000000 0
1 40 0000008 deadbeef efbeadde
4 00 0000000 00000000 0
3 05 0000000 00000000 0
1 05 0000000 11112222 0
4 00 0000000 00000000 0
5 00 0000000 00000000 0
3 01 0000000 00000000 0
1 01 0000000 56781234 56781234
1 01 0000004 cafef00d cafef00d
1 01 0100000 13572468 13572468
1 01 0000008 0badf00d 0badf00d
1 01 0000010 89abcdef 89abcdef
2 00 0000000 00000010 1
5 00 0000000 00000000 1
4 00 0000000 00000000 0
5 00 0000000 00000000 1
2 00 0000000 00000001 1
2 00 0000000 00000002 2
2 00 0000000 00000004 2
2 00 0000000 0000000c 0
2 00 0001000 00000010 4
3 01 0000000 00000000 0
2 00 0000000 00000000 0
4 00 0000000 00000000 0
2 00 0001000 00000030 0
0 00 0000000 00000000 0
5 00 0000000 00000000 0
2 00 0000000 00000000 0

// File: test/loader_tb.sv
`include "loader_defines.svh"

module loader_tb;
	timeunit 1ns;
	timeprecision 1ps;

	logic        clk_1x;
	logic        rst_n;
	logic        reset_req;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic [26:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic        ioctl_wr;
	logic        ioctl_wait;
	logic [9:0]  pif_wraddress;
	logic [31:0] pif_wrdata;
	logic        pif_wren;
	logic [26:0] mem_addr;
	logic [31:0] mem_data;
	logic        mem_valid;
	logic        mem_ready;
	logic        img_mounted;
	logic        img_readonly;
	logic [31:0] img_size;
	logic        osd_status;
	logic        load_req;
	logic        save_req;
	logic        autosave_off;
	logic        cart_loaded;
	logic        bk_load;
	logic        bk_save;
	logic        use_img;

	int          errors = 0;
	int          timeouts = 0;
	logic        timed_out = 1'b0;
	logic        wait_seen = 1'b0;
	int          mem_words = 0;
	logic [15:0] lfsr = 16'd6478;
	logic [9:0]  pif_addr_q[$];
	logic [31:0] pif_data_q[$];
	logic [26:0] mem_addr_q[$];
	logic [31:0] mem_data_q[$];

	clock_gen u_clock (.reset_req(reset_req), .clk_1x(clk_1x), .rst_n(rst_n));

	loader_top DUT (.*);

	bind write_router loader_checker u_router_chk (
		.clk_1x(clk_1x), .rst_n(rst_n), .valid(mem_valid), .ready(mem_ready),
		.addr(mem_addr), .data(mem_data), .pulse(pif_wren)
	);

	// A PIF word is accepted at once and stays valid for one cycle only
	bind halfword_assembler loader_checker u_asm_chk (
		.clk_1x(clk_1x), .rst_n(rst_n), .valid(word_valid), .ready(word_ready),
		.addr(word_addr), .data(word_data),
		.pulse(word_valid && (word_target == loader_pkg::TGT_PIF))
	);

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] exp_val);
		assert (got === exp_val) else begin
			errors++;
			$display("Error at %0t ns: %s got %h expected %h", $time, name, got, exp_val);
		end
	endtask

	task automatic flag_timeout(input string what);
		timeouts++;
		$display("Timeout while waiting for %s", what);
		timed_out = 1'b1;
	endtask

	task automatic end_run();
		$display("Checks done: %0d errors, %0d timeouts", errors, timeouts);
		if ((errors == 0) && (timeouts == 0)) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// ========================================
	// Memory ready model and monitors
	// ========================================

	initial begin : mem_model
		int stall;
		mem_ready = 1'b0;
		forever begin
			@(negedge clk_1x);
			if (mem_valid && !mem_ready) begin
				stall = 0;
				repeat (2) begin
					lfsr = lfsr_next(lfsr);
					stall = stall * 2 + int'(lfsr[0]);
				end
				repeat (stall) @(posedge clk_1x);
				@(posedge clk_1x);
				mem_ready <= 1'b1;
				@(posedge clk_1x);
				mem_ready <= 1'b0;
			end
		end
	end

	always @(negedge clk_1x) begin
		if (pif_wren) begin
			pif_addr_q.push_back(pif_wraddress);
			pif_data_q.push_back(pif_wrdata);
		end
		if (mem_valid && mem_ready) begin
			mem_addr_q.push_back(mem_addr);
			mem_data_q.push_back(mem_data);
			mem_words++;
		end
		if (ioctl_wait && mem_valid && !mem_ready) begin
			wait_seen = 1'b1;
		end
	end

	initial begin
		wait (timed_out);
		end_run();
	end

	// ========================================
	// Host side tasks
	// ========================================

	task automatic wait_host_free();
		int n;
		for (n = 0; n < 50 && ioctl_wait; n++) begin
			@(negedge clk_1x);
		end
		if (ioctl_wait) begin
			flag_timeout("ioctl_wait to drop");
		end
	endtask

	task automatic wait_reset_level(input logic level);
		int n;
		for (n = 0; n < 20 && (rst_n !== level); n++) begin
			@(negedge clk_1x);
		end
		if (rst_n !== level) begin
			flag_timeout("reset to change");
		end
	endtask

	task automatic write_half(input logic [7:0] idx, input logic [26:0] a,
			input logic [15:0] d);
		@(posedge clk_1x);
		ioctl_index <= idx;
		ioctl_addr  <= a;
		ioctl_dout  <= d;
		ioctl_wr    <= 1'b1;
		@(posedge clk_1x);
		ioctl_wr <= 1'b0;
	endtask

	task automatic write_pair(input logic [7:0] idx, input logic [26:0] a,
			input logic [31:0] d, input logic [31:0] exp_val);
		logic [26:0] cart_addr;
		cart_addr = a + `CART_BASE;
		wait_host_free();
		write_half(idx, a, d[15:0]);
		wait_host_free();
		write_half(idx, a + 27'd2, d[31:16]);
		// Host trusts ioctl_wait three cycles after the high half
		repeat (2) @(posedge clk_1x);
		@(negedge clk_1x);
		wait_host_free();
		repeat (2) @(negedge clk_1x);
		if (idx[5:0] == 6'd0) begin
			compare_value("pif_wren count", pif_data_q.size(), 1);
			compare_value("mem_valid count", mem_data_q.size(), 0);
			if (pif_data_q.size() > 0) begin
				compare_value("pif_wrdata", pif_data_q[0], exp_val);
				compare_value("pif_wraddress", 32'(pif_addr_q[0]), {22'd0, idx[6], a[10:2]});
			end
		end else if (idx[5:0] == 6'd1) begin
			compare_value("mem_valid count", mem_data_q.size(), 1);
			compare_value("pif_wren count", pif_data_q.size(), 0);
			if (mem_data_q.size() > 0) begin
				compare_value("mem_data", mem_data_q[0], exp_val);
				compare_value("mem_addr", 32'(mem_addr_q[0]), 32'(cart_addr));
			end
		end else begin
			compare_value("pif_wren count", pif_data_q.size(), 0);
			compare_value("mem_valid count", mem_data_q.size(), 0);
		end
		pif_addr_q.delete();
		pif_data_q.delete();
		mem_addr_q.delete();
		mem_data_q.delete();
	endtask

	task automatic backup_event(input logic [31:0] size, input logic [31:0] flags,
			input logic [31:0] exp_val);
		@(posedge clk_1x);
		load_req     <= flags[0];
		save_req     <= flags[1];
		osd_status   <= flags[2];
		autosave_off <= flags[3];
		img_mounted  <= flags[4];
		img_readonly <= flags[5];
		img_size     <= size;
		@(posedge clk_1x);
		load_req    <= 1'b0;
		save_req    <= 1'b0;
		osd_status  <= 1'b0;
		img_mounted <= 1'b0;
		@(negedge clk_1x);
		compare_value("bk_load", 32'(bk_load), 32'(exp_val[0]));
		compare_value("bk_save", 32'(bk_save), 32'(exp_val[1]));
		compare_value("use_img", 32'(use_img), 32'(exp_val[2]));
		@(negedge clk_1x);
		compare_value("bk_load", 32'(bk_load), 0);
		compare_value("bk_save", 32'(bk_save), 0);
	endtask

	// ========================================
	// Stimulus from file
	// ========================================

	initial begin
		int          fd;
		int          n;
		string       line;
		logic [31:0] op;
		logic [31:0] idx;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] exp_val;
		reset_req      = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		osd_status     = 1'b0;
		load_req       = 1'b0;
		save_req       = 1'b0;
		autosave_off   = 1'b0;
		@(negedge clk_1x);
		wait_reset_level(1'b1);
		fd = $fopen("test/loader_input.txt", "r");
		assert (fd != 0) else begin
			errors++;
			$display("Could not open the stimulus file test/loader_input.txt");
		end
		while ((fd != 0) && !timed_out && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if ((n > 1) && (line.getc(0) != "#")) begin
				n = $sscanf(line, "%h %h %h %h %h", op, idx, addr, data, exp_val);
				if (n == 5) begin
					case (op)
						0: begin
							@(posedge clk_1x);
							reset_req      <= 1'b1;
							ioctl_download <= 1'b0;
							@(posedge clk_1x);
							reset_req <= 1'b0;
							wait_reset_level(1'b0);
							wait_reset_level(1'b1);
						end
						1: write_pair(idx[7:0], addr[26:0], data, exp_val);
						2: backup_event(addr, data, exp_val);
						3: begin
							@(posedge clk_1x);
							ioctl_index    <= idx[7:0];
							ioctl_download <= 1'b1;
							repeat (3) @(posedge clk_1x);
						end
						4: begin
							@(posedge clk_1x);
							ioctl_download <= 1'b0;
							repeat (3) @(posedge clk_1x);
						end
						default: begin
							@(negedge clk_1x);
							compare_value("cart_loaded", 32'(cart_loaded), exp_val);
						end
					endcase
				end
			end
		end
		if (!timed_out) begin
			assert ((mem_words == 0) || wait_seen) else begin
				errors++;
				$display("ioctl_wait was never high during a memory stall");
			end
			end_run();
		end
	end

endmodule
